/* verilog/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Cache geometry
`define DC_WAYS        2
`define DC_SETS        128
`define DC_INDEX_BITS  7
`define DC_OFFSET_BITS 3
`define DC_TAG_BITS    20
`define DC_LINE_WORDS  8

`endif

/* verilog/dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

   typedef logic [31:0]                    addr_t;
   typedef logic [31:0]                    word_t;
   typedef logic [`DC_TAG_BITS-1:0]        tag_t;
   typedef logic [`DC_INDEX_BITS-1:0]      index_t;
   typedef logic [`DC_OFFSET_BITS-1:0]     offset_t;
   typedef logic [3:0]                     byte_en_t;
   typedef logic [`DC_LINE_WORDS*32-1:0]   line_t;
   typedef logic [`DC_WAYS-1:0]            way_mask_t;

   // Miss handling sequence
   typedef enum logic [2:0] {
      IDLE,
      WB_ADDR,
      WB_DATA,
      WB_RESP,
      FILL_ADDR,
      FILL_DATA,
      INSTALL
   } miss_state_e;

endpackage

/* verilog/cache_way.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module cache_way (
   input  logic                clk,
   input  logic                reset,
   input  dcache_pkg::index_t  i_index,
   input  dcache_pkg::tag_t    i_tag,
   input  dcache_pkg::offset_t i_offset,
   input  dcache_pkg::byte_en_t i_byte_en,
   input  dcache_pkg::word_t   i_wdata,
   input  logic                i_store_en,
   input  logic                i_fill_en,
   input  dcache_pkg::line_t   i_fill_line,
   output logic                o_hit,
   output dcache_pkg::word_t   o_rdata,
   output dcache_pkg::tag_t    o_tag,
   output logic                o_dirty,
   output dcache_pkg::line_t   o_line
);

   dcache_pkg::tag_t  tag_mem  [`DC_SETS];
   dcache_pkg::line_t data_mem [`DC_SETS];
   logic [`DC_SETS-1:0] valid;
   logic [`DC_SETS-1:0] dirty;

   // Combinational lookup of the indexed entry
   assign o_tag   = tag_mem[i_index];
   assign o_line  = data_mem[i_index];
   assign o_hit   = valid[i_index] && (tag_mem[i_index] == i_tag);
   assign o_rdata = o_line[32*i_offset +: 32];
   // Only a valid line can need a writeback
   assign o_dirty = valid[i_index] && dirty[i_index];

   always_ff @(posedge clk) begin
      if (reset) begin
         valid <= '0;
         dirty <= '0;
      end else if (i_fill_en) begin
         valid[i_index] <= 1'b1;
         dirty[i_index] <= 1'b0;
      end else if (i_store_en) begin
         dirty[i_index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_fill_en) begin
         tag_mem[i_index]  <= i_tag;
         data_mem[i_index] <= i_fill_line;
      end else if (i_store_en) begin
         for (int b = 0; b < 4; b++) begin
            if (i_byte_en[b]) begin
               data_mem[i_index][32*i_offset + 8*b +: 8] <= i_wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

/* verilog/miss_controller.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module miss_controller (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  i_read,
   input  logic                  i_write,
   input  dcache_pkg::tag_t      i_tag,
   input  dcache_pkg::index_t    i_index,
   input  logic                  i_hit,
   input  dcache_pkg::way_mask_t i_hit_way,
   input  dcache_pkg::way_mask_t i_victim_way,
   input  logic                  i_victim_dirty,
   input  dcache_pkg::tag_t      i_victim_tag,
   input  dcache_pkg::line_t     i_victim_line,
   input  logic                  i_arready,
   input  dcache_pkg::word_t     i_rdata,
   input  logic                  i_rvalid,
   input  logic                  i_rlast,
   input  logic                  i_awready,
   input  logic                  i_wready,
   input  logic                  i_bvalid,
   output logic                  o_stall,
   output logic                  o_touch,
   output dcache_pkg::way_mask_t o_store_en,
   output dcache_pkg::way_mask_t o_fill_en,
   output dcache_pkg::line_t     o_fill_line,
   output dcache_pkg::addr_t     o_araddr,
   output logic                  o_arvalid,
   output dcache_pkg::addr_t     o_awaddr,
   output logic                  o_awvalid,
   output dcache_pkg::word_t     o_wdata,
   output logic                  o_wvalid,
   output logic                  o_wlast
);

   dcache_pkg::miss_state_e   state;
   dcache_pkg::way_mask_t     victim_way;
   dcache_pkg::line_t         victim_line;
   dcache_pkg::line_t         fill_buf;
   logic [`DC_OFFSET_BITS-1:0] beat;
   logic                      request;
   dcache_pkg::addr_t         fill_addr;

   assign request   = i_read || i_write;
   // Refill always targets the line of the held processor address
   assign fill_addr = {i_tag, i_index, {(`DC_OFFSET_BITS + 2){1'b0}}};

   assign o_stall    = (state != dcache_pkg::IDLE) || (request && !i_hit);
   assign o_touch    = (state == dcache_pkg::IDLE) && request && i_hit;
   assign o_store_en = (o_touch && i_write) ? i_hit_way : '0;
   assign o_fill_en  = (state == dcache_pkg::INSTALL) ? victim_way : '0;
   assign o_fill_line = fill_buf;

   assign o_wdata = victim_line[32*beat +: 32];
   assign o_wlast = (state == dcache_pkg::WB_DATA) &&
                    (beat == `DC_OFFSET_BITS'(`DC_LINE_WORDS - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= dcache_pkg::IDLE;
         o_arvalid <= 1'b0;
         o_awvalid <= 1'b0;
         o_wvalid  <= 1'b0;
         beat      <= '0;
      end else begin
         case (state)
            dcache_pkg::IDLE: begin
               beat <= '0;
               if (request && !i_hit) begin
                  if (i_victim_dirty) begin
                     o_awvalid <= 1'b1;
                     state     <= dcache_pkg::WB_ADDR;
                  end else begin
                     o_arvalid <= 1'b1;
                     state     <= dcache_pkg::FILL_ADDR;
                  end
               end
            end
            dcache_pkg::WB_ADDR: begin
               if (i_awready) begin
                  o_awvalid <= 1'b0;
                  o_wvalid  <= 1'b1;
                  state     <= dcache_pkg::WB_DATA;
               end
            end
            dcache_pkg::WB_DATA: begin
               if (i_wready) begin
                  beat <= beat + 1'b1;
                  if (o_wlast) begin
                     o_wvalid <= 1'b0;
                     state    <= dcache_pkg::WB_RESP;
                  end
               end
            end
            dcache_pkg::WB_RESP: begin
               if (i_bvalid) begin
                  o_arvalid <= 1'b1;
                  state     <= dcache_pkg::FILL_ADDR;
               end
            end
            dcache_pkg::FILL_ADDR: begin
               beat <= '0;
               if (i_arready) begin
                  o_arvalid <= 1'b0;
                  state     <= dcache_pkg::FILL_DATA;
               end
            end
            dcache_pkg::FILL_DATA: begin
               if (i_rvalid) begin
                  beat <= beat + 1'b1;
                  if (i_rlast) begin
                     state <= dcache_pkg::INSTALL;
                  end
               end
            end
            dcache_pkg::INSTALL: state <= dcache_pkg::IDLE;
            default: state <= dcache_pkg::IDLE;
         endcase
      end
   end

   // Burst payload and addresses
   always_ff @(posedge clk) begin
      if (state == dcache_pkg::IDLE && request && !i_hit) begin
         victim_way  <= i_victim_way;
         victim_line <= i_victim_line;
         o_awaddr    <= {i_victim_tag, i_index, {(`DC_OFFSET_BITS + 2){1'b0}}};
         o_araddr    <= fill_addr;
      end
      if (state == dcache_pkg::FILL_DATA && i_rvalid) begin
         fill_buf[32*beat +: 32] <= i_rdata;
      end
   end

endmodule

/* verilog/hit_select.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module hit_select (
   input  logic                  clk,
   input  logic                  reset,
   input  dcache_pkg::index_t    i_index,
   input  dcache_pkg::way_mask_t i_way_hit,
   input  dcache_pkg::word_t     i_way_rdata [`DC_WAYS],
   input  dcache_pkg::tag_t      i_way_tag   [`DC_WAYS],
   input  logic                  i_way_dirty [`DC_WAYS],
   input  dcache_pkg::line_t     i_way_line  [`DC_WAYS],
   input  logic                  i_touch,
   output logic                  o_hit,
   output dcache_pkg::way_mask_t o_hit_way,
   output dcache_pkg::word_t     o_rdata,
   output dcache_pkg::way_mask_t o_victim_way,
   output logic                  o_victim_dirty,
   output dcache_pkg::tag_t      o_victim_tag,
   output dcache_pkg::line_t     o_victim_line
);

   // One bit per set naming the least recently used way
   logic [`DC_SETS-1:0] lru;
   logic                lru_way;

   assign o_hit     = |i_way_hit;
   assign o_hit_way = i_way_hit;
   assign o_rdata   = i_way_hit[1] ? i_way_rdata[1] : i_way_rdata[0];

   assign lru_way        = lru[i_index];
   assign o_victim_way   = {lru_way, ~lru_way};
   assign o_victim_dirty = i_way_dirty[lru_way];
   assign o_victim_tag   = i_way_tag[lru_way];
   assign o_victim_line  = i_way_line[lru_way];

   always_ff @(posedge clk) begin
      if (reset) begin
         lru <= '0;
      end else if (i_touch) begin
         // The way that did not hit becomes the LRU one
         lru[i_index] <= i_way_hit[0];
      end
   end

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 i_read,
   input  logic                 i_write,
   input  dcache_pkg::addr_t    i_addr,
   input  dcache_pkg::word_t    i_wdata,
   input  dcache_pkg::byte_en_t i_byte_en,
   input  logic                 i_arready,
   input  dcache_pkg::word_t    i_rdata,
   input  logic                 i_rvalid,
   input  logic                 i_rlast,
   input  logic                 i_awready,
   input  logic                 i_wready,
   input  logic                 i_bvalid,
   output dcache_pkg::word_t    o_rdata,
   output logic                 o_stall,
   output dcache_pkg::addr_t    o_araddr,
   output logic                 o_arvalid,
   output dcache_pkg::addr_t    o_awaddr,
   output logic                 o_awvalid,
   output dcache_pkg::word_t    o_wdata,
   output logic                 o_wvalid,
   output logic                 o_wlast
);

   dcache_pkg::tag_t      tag;
   dcache_pkg::index_t    index;
   dcache_pkg::offset_t   offset;

   dcache_pkg::way_mask_t store_en;
   dcache_pkg::way_mask_t fill_en;
   dcache_pkg::line_t     fill_line;
   logic                  touch;

   dcache_pkg::way_mask_t way_hit;
   dcache_pkg::word_t     way_rdata [`DC_WAYS];
   dcache_pkg::tag_t      way_tag   [`DC_WAYS];
   logic                  way_dirty [`DC_WAYS];
   dcache_pkg::line_t     way_line  [`DC_WAYS];

   logic                  hit;
   dcache_pkg::way_mask_t hit_way;
   dcache_pkg::way_mask_t victim_way;
   logic                  victim_dirty;
   dcache_pkg::tag_t      victim_tag;
   dcache_pkg::line_t     victim_line;

   // Address layout is tag | index | word offset | byte
   assign tag    = i_addr[31 -: `DC_TAG_BITS];
   assign index  = i_addr[`DC_OFFSET_BITS + 2 +: `DC_INDEX_BITS];
   assign offset = i_addr[2 +: `DC_OFFSET_BITS];

   miss_controller ctrl_i (
      .clk            (clk),
      .reset          (reset),
      .i_read         (i_read),
      .i_write        (i_write),
      .i_tag          (tag),
      .i_index        (index),
      .i_hit          (hit),
      .i_hit_way      (hit_way),
      .i_victim_way   (victim_way),
      .i_victim_dirty (victim_dirty),
      .i_victim_tag   (victim_tag),
      .i_victim_line  (victim_line),
      .i_arready      (i_arready),
      .i_rdata        (i_rdata),
      .i_rvalid       (i_rvalid),
      .i_rlast        (i_rlast),
      .i_awready      (i_awready),
      .i_wready       (i_wready),
      .i_bvalid       (i_bvalid),
      .o_stall        (o_stall),
      .o_touch        (touch),
      .o_store_en     (store_en),
      .o_fill_en      (fill_en),
      .o_fill_line    (fill_line),
      .o_araddr       (o_araddr),
      .o_arvalid      (o_arvalid),
      .o_awaddr       (o_awaddr),
      .o_awvalid      (o_awvalid),
      .o_wdata        (o_wdata),
      .o_wvalid       (o_wvalid),
      .o_wlast        (o_wlast)
   );

   for (genvar w = 0; w < `DC_WAYS; w++) begin : ways
      cache_way way_i (
         .clk         (clk),
         .reset       (reset),
         .i_index     (index),
         .i_tag       (tag),
         .i_offset    (offset),
         .i_byte_en   (i_byte_en),
         .i_wdata     (i_wdata),
         .i_store_en  (store_en[w]),
         .i_fill_en   (fill_en[w]),
         .i_fill_line (fill_line),
         .o_hit       (way_hit[w]),
         .o_rdata     (way_rdata[w]),
         .o_tag       (way_tag[w]),
         .o_dirty     (way_dirty[w]),
         .o_line      (way_line[w])
      );
   end

   hit_select select_i (
      .clk            (clk),
      .reset          (reset),
      .i_index        (index),
      .i_way_hit      (way_hit),
      .i_way_rdata    (way_rdata),
      .i_way_tag      (way_tag),
      .i_way_dirty    (way_dirty),
      .i_way_line     (way_line),
      .i_touch        (touch),
      .o_hit          (hit),
      .o_hit_way      (hit_way),
      .o_rdata        (o_rdata),
      .o_victim_way   (victim_way),
      .o_victim_dirty (victim_dirty),
      .o_victim_tag   (victim_tag),
      .o_victim_line  (victim_line)
   );

endmodule

/* testbench/dcache_properties.sv */
`timescale 1ns/1ps

module dcache_properties (
   input logic clk,
   input logic reset,
   input logic o_stall,
   input logic o_arvalid,
   input logic i_arready,
   input logic o_awvalid,
   input logic i_awready,
   input logic o_wvalid,
   input logic o_wlast
);

   // An address valid that was not accepted stays up
   ar_hold: assert property (@(posedge clk) disable iff (reset)
      (o_arvalid && !i_arready) |=> o_arvalid)
      else $error("read address valid dropped before ready");

   aw_hold: assert property (@(posedge clk) disable iff (reset)
      (o_awvalid && !i_awready) |=> o_awvalid)
      else $error("write address valid dropped before ready");

   wlast_with_valid: assert property (@(posedge clk) disable iff (reset)
      o_wlast |-> o_wvalid)
      else $error("write last flag without write valid");

   // Refill and writeback never overlap
   ar_w_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(o_arvalid && o_wvalid))
      else $error("read address and write data valid together");

   busy_stalls: assert property (@(posedge clk) disable iff (reset)
      (o_arvalid || o_awvalid || o_wvalid) |-> o_stall)
      else $error("memory traffic without a processor stall");

endmodule

bind miss_controller dcache_properties props_i (
   .clk       (clk),
   .reset     (reset),
   .o_stall   (o_stall),
   .o_arvalid (o_arvalid),
   .i_arready (i_arready),
   .o_awvalid (o_awvalid),
   .i_awready (i_awready),
   .o_wvalid  (o_wvalid),
   .o_wlast   (o_wlast)
);

/* testbench/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

   localparam int          CLK_PERIOD  = 40;
   localparam int unsigned SEED        = 32'ha505_a770;
   localparam logic [31:0] MEM_PATTERN = 32'h5a5a_0000;
   localparam int          MEM_WORDS   = 4096;
   localparam int          TRACE_MAX   = 32;
   localparam int          CYCLE_LIMIT = 300;
   localparam logic [31:0] TRACE_END   = 32'hffff_ffff;

   logic        clk = 1'b0;
   logic        reset;
   logic        i_read;
   logic        i_write;
   logic [31:0] i_addr;
   logic [31:0] i_wdata;
   logic [3:0]  i_byte_en;
   logic        i_arready;
   logic [31:0] i_rdata;
   logic        i_rvalid;
   logic        i_rlast;
   logic        i_awready;
   logic        i_wready;
   logic        i_bvalid;
   logic [31:0] o_rdata;
   logic        o_stall;
   logic [31:0] o_araddr;
   logic        o_arvalid;
   logic [31:0] o_awaddr;
   logic        o_awvalid;
   logic [31:0] o_wdata;
   logic        o_wvalid;
   logic        o_wlast;

   // Backing memory and the flat view the processor expects
   logic [31:0] mem         [MEM_WORDS];
   logic [31:0] ref_mem     [MEM_WORDS];
   logic [31:0] trace_words [TRACE_MAX*5];

   int          check_errors = 0;
   int          timeouts = 0;
   int          wb_count;
   logic [31:0] last_wb_addr;

   dcache_top dut_i (
      .clk       (clk),
      .reset     (reset),
      .i_read    (i_read),
      .i_write   (i_write),
      .i_addr    (i_addr),
      .i_wdata   (i_wdata),
      .i_byte_en (i_byte_en),
      .i_arready (i_arready),
      .i_rdata   (i_rdata),
      .i_rvalid  (i_rvalid),
      .i_rlast   (i_rlast),
      .i_awready (i_awready),
      .i_wready  (i_wready),
      .i_bvalid  (i_bvalid),
      .o_rdata   (o_rdata),
      .o_stall   (o_stall),
      .o_araddr  (o_araddr),
      .o_arvalid (o_arvalid),
      .o_awaddr  (o_awaddr),
      .o_awvalid (o_awvalid),
      .o_wdata   (o_wdata),
      .o_wvalid  (o_wvalid),
      .o_wlast   (o_wlast)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] initial_word(input int word_index);
      return 32'(word_index * 4) ^ MEM_PATTERN;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      check_errors++;
   endtask

   task automatic finish_run();
      $display("Closing: %0d check failures, %0d timeouts", check_errors, timeouts);
      if (check_errors == 0 && timeouts == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   endtask

   // Op bit 0 marks a write, bit 1 a required hit and bit 2 a dirty eviction
   task automatic run_access(input int n, output logic timed_out);
      logic [31:0] op;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  be;
      logic [31:0] expected;
      logic [31:0] got;
      int          wb_before;
      int          stall_cycles;
      logic        done;
      op        = trace_words[5*n];
      addr      = trace_words[5*n + 1];
      wdata     = trace_words[5*n + 2];
      be        = trace_words[5*n + 3][3:0];
      expected  = trace_words[5*n + 4];
      timed_out = 1'b0;
      @(negedge clk);
      i_read       = !op[0];
      i_write      = op[0];
      i_addr       = addr;
      i_wdata      = wdata;
      i_byte_en    = be;
      wb_before    = wb_count;
      stall_cycles = 0;
      done         = 1'b0;
      got          = '0;
      for (int cycle = 0; cycle < CYCLE_LIMIT && !done; cycle++) begin
         @(posedge clk);
         if (o_stall) begin
            stall_cycles++;
         end else begin
            done = 1'b1;
            got  = o_rdata;
         end
      end
      if (!done) begin
         $display("Timeout: access %0d to address %h still stalled after %0d cycles",
                  n, addr, CYCLE_LIMIT);
         timeouts++;
         timed_out = 1'b1;
      end else begin
         if (!op[0] && got !== expected) begin
            report_mismatch($sformatf("access %0d read of %h", n, addr), expected, got);
         end
         if (op[1] && stall_cycles != 0) begin
            report_mismatch($sformatf("access %0d stall cycles", n), '0, 32'(stall_cycles));
         end
         if (wb_count - wb_before != (op[2] ? 1 : 0)) begin
            report_mismatch($sformatf("access %0d writeback count", n), 32'(op[2]),
                            32'(wb_count - wb_before));
         end
         if (op[2] && last_wb_addr !== wdata) begin
            report_mismatch($sformatf("access %0d writeback address", n), wdata,
                            last_wb_addr);
         end
         if (op[0]) begin
            for (int b = 0; b < 4; b++) begin
               if (be[b]) begin
                  ref_mem[addr[13:2]][8*b +: 8] = wdata[8*b +: 8];
               end
            end
         end
      end
   endtask

   initial begin
      int   n;
      logic timed_out;
      reset     = 1'b1;
      i_read    = 1'b0;
      i_write   = 1'b0;
      i_addr    = '0;
      i_wdata   = '0;
      i_byte_en = '0;
      for (int w = 0; w < MEM_WORDS; w++) begin
         ref_mem[w] = initial_word(w);
      end
      for (int i = 0; i < TRACE_MAX*5; i++) begin
         trace_words[i] = TRACE_END;
      end
      $readmemh("testbench/dcache_trace.txt", trace_words);
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      if (o_stall !== 1'b0) report_mismatch("reset o_stall", '0, 32'(o_stall));
      if (o_arvalid !== 1'b0) report_mismatch("reset o_arvalid", '0, 32'(o_arvalid));
      if (o_awvalid !== 1'b0) report_mismatch("reset o_awvalid", '0, 32'(o_awvalid));
      if (o_wvalid !== 1'b0) report_mismatch("reset o_wvalid", '0, 32'(o_wvalid));
      if (o_wlast !== 1'b0) report_mismatch("reset o_wlast", '0, 32'(o_wlast));
      n         = 0;
      timed_out = 1'b0;
      while (!timed_out && n < TRACE_MAX && trace_words[5*n] != TRACE_END) begin
         run_access(n, timed_out);
         n++;
      end
      @(negedge clk);
      i_read  = 1'b0;
      i_write = 1'b0;
      if (n == 0) begin
         $display("The trace file held no accesses");
         check_errors++;
      end
      finish_run();
   end

   // Memory model driven on the falling edge with random ready delays
   initial begin : memory_model
      int unsigned seed_value;
      int          ar_wait;
      int          r_wait;
      int          aw_wait;
      int          w_wait;
      int          wr_phase;
      logic        rd_active;
      logic [31:0] rd_addr;
      logic [31:0] wr_addr;
      logic [2:0]  rd_beat;
      logic [2:0]  wr_beat;
      seed_value   = $urandom(SEED);
      i_arready    = 1'b0;
      i_rdata      = '0;
      i_rvalid     = 1'b0;
      i_rlast      = 1'b0;
      i_awready    = 1'b0;
      i_wready     = 1'b0;
      i_bvalid     = 1'b0;
      wb_count     = 0;
      last_wb_addr = '0;
      ar_wait      = 0;
      r_wait       = 0;
      aw_wait      = 0;
      w_wait       = 0;
      wr_phase     = 0;
      rd_active    = 1'b0;
      rd_addr      = '0;
      wr_addr      = '0;
      rd_beat      = '0;
      wr_beat      = '0;
      for (int w = 0; w < MEM_WORDS; w++) begin
         mem[w] = initial_word(w);
      end
      forever begin
         @(negedge clk);
         i_arready = 1'b0;
         i_rvalid  = 1'b0;
         i_rlast   = 1'b0;
         i_awready = 1'b0;
         i_wready  = 1'b0;
         i_bvalid  = 1'b0;
         if (!rd_active) begin
            if (o_arvalid) begin
               if (ar_wait == 0) begin
                  // Refill fetches the aligned line of the access in progress
                  if (o_araddr !== {i_addr[31:5], 5'b0}) begin
                     report_mismatch("refill address", {i_addr[31:5], 5'b0}, o_araddr);
                  end
                  i_arready = 1'b1;
                  rd_addr   = o_araddr;
                  rd_beat   = '0;
                  rd_active = 1'b1;
                  ar_wait   = $urandom % 4;
               end else begin
                  ar_wait--;
               end
            end
         end else if (r_wait == 0) begin
            i_rvalid = 1'b1;
            i_rdata  = mem[{rd_addr[13:5], rd_beat}];
            i_rlast  = (rd_beat == 3'd7);
            if (rd_beat == 3'd7) begin
               rd_active = 1'b0;
            end
            rd_beat++;
            r_wait = $urandom % 4;
         end else begin
            r_wait--;
         end
         if (wr_phase == 0) begin
            if (o_awvalid) begin
               if (aw_wait == 0) begin
                  i_awready    = 1'b1;
                  wr_addr      = o_awaddr;
                  wr_beat      = '0;
                  wr_phase     = 1;
                  last_wb_addr = o_awaddr;
                  wb_count++;
                  aw_wait = $urandom % 4;
               end else begin
                  aw_wait--;
               end
            end
         end else if (wr_phase == 1) begin
            if (o_wvalid && w_wait == 0) begin
               i_wready = 1'b1;
               if (o_wlast !== (wr_beat == 3'd7)) begin
                  report_mismatch("writeback last flag", 32'(wr_beat == 3'd7), 32'(o_wlast));
               end
               if (o_wdata !== ref_mem[{wr_addr[13:5], wr_beat}]) begin
                  report_mismatch("writeback data", ref_mem[{wr_addr[13:5], wr_beat}],
                                  o_wdata);
               end
               mem[{wr_addr[13:5], wr_beat}] = o_wdata;
               if (wr_beat == 3'd7) begin
                  wr_phase = 2;
               end
               wr_beat++;
               w_wait = $urandom % 4;
            end else if (o_wvalid) begin
               w_wait--;
            end
         end else begin
            i_bvalid = 1'b1;
            wr_phase = 0;
         end
      end
   end

endmodule

/* testbench/dcache_trace.txt */
// Columns: op, address, write data, byte enables, expected read data
// Op bits: 0 write, 1 must hit without stall, 2 evicts dirty line at write data column
0 00001000 00000000 0 5a5a1000
2 00001004 00000000 0 5a5a1004
2 0000101c 00000000 0 5a5a101c
3 00001008 11223344 3 00000000
2 00001008 00000000 0 5a5a3344
1 00002010 deadbeef c 00000000
2 00002010 00000000 0 dead2010
2 00002014 00000000 0 5a5a2014
4 00003004 00001000 0 5a5a3004
4 00001008 00002000 0 5a5a3344
0 00002010 00000000 0 dead2010
2 00001000 00000000 0 5a5a1000
1 00000ffc 0badf00d f 00000000
2 00000ffc 00000000 0 0badf00d
2 00000fe0 00000000 0 5a5a0fe0

/* src.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/cache_way.sv
verilog/miss_controller.sv
verilog/hit_select.sv
verilog/dcache_top.sv
testbench/dcache_properties.sv
testbench/dcache_tb.sv

/* Makefile */
SIM_LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module dcache_tb -f src.f

obj_dir/Vdcache_tb: src.f verilog/*.sv verilog/*.svh testbench/*.sv
	verilator --binary --timing --assert --top-module dcache_tb -f src.f

sim: obj_dir/Vdcache_tb
	./obj_dir/Vdcache_tb > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@if grep -q "Simulation failed" $(SIM_LOG); then echo "RESULT: FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(SIM_LOG); then \
		echo "RESULT: FAIL"; exit 1; fi
	@echo "RESULT: PASS"

clean:
	rm -rf obj_dir $(SIM_LOG)
